/* all.f */
verilog/aluPkg.sv
verilog/addSubLogic.sv
verilog/barrelShifter.sv
verilog/singleCycleUnit.sv
verilog/boothStage.sv
verilog/multPipeline.sv
verilog/aluTop.sv
verification/aluTop_checker.sv
verification/clockGen.sv
verification/aluTop_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= aluTop_tb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* verification/aluTop_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module aluTop_tb;

	typedef struct packed {
		aluPkg::aluRequest_t request;
		aluPkg::aluResult_t  expAlu;
		aluPkg::mulResult_t  expMul;
	} testRow_t;

	logic                clk;
	logic                rst;
	aluPkg::aluRequest_t request;
	aluPkg::aluResult_t  alu;
	aluPkg::mulResult_t  mul;

	testRow_t           rows [$];
	aluPkg::mulResult_t pendingMul [$];
	aluPkg::mulResult_t noProduct;
	int                 cycleCount;
	int                 cycleLimit;

	clockGen i_clockGen (
		.clk (clk)
	);

	aluTop i_aluTop (
		.clk     (clk),
		.rst     (rst),
		.request (request),
		.alu     (alu),
		.mul     (mul)
	);

	function automatic aluPkg::aluResult_t expectAlu(input aluPkg::aluRequest_t req);
		aluPkg::aluResult_t res;
		res = '0;
		case (req.opcode)
			aluPkg::OP_ADD: res.result = req.opA + req.opB;
			aluPkg::OP_SUB: begin
				res.result = req.opA - req.opB;
				res.notEqual = (req.opA != req.opB);
				res.lessThan = ($signed(req.opA) < $signed(req.opB));
			end
			aluPkg::OP_AND: res.result = req.opA & req.opB;
			aluPkg::OP_OR:  res.result = req.opA | req.opB;
			aluPkg::OP_SLL: res.result = req.opA << req.shiftAmt;
			aluPkg::OP_SRA: res.result = $signed(req.opA) >>> req.shiftAmt;
			default:        res.result = '0;
		endcase
		return res;
	endfunction

	function automatic aluPkg::mulResult_t expectMul(input aluPkg::aluRequest_t req);
		aluPkg::mulResult_t res;
		logic signed [63:0] full;
		res = '0;
		if (req.opcode == aluPkg::OP_MUL) begin
			full = $signed({{32{req.opA[31]}}, req.opA}) * $signed({{32{req.opB[31]}}, req.opB});
			res.product = full[31:0];
			res.overflow = (full > 64'sd2147483647) || (full < -64'sd2147483648);
			res.valid = 1'b1;
		end
		return res;
	endfunction

	task automatic addRow(input logic [31:0] opA, input logic [31:0] opB,
			input aluPkg::aluOp_t opcode, input logic [4:0] shiftAmt);
		testRow_t row;
		row.request.opA = opA;
		row.request.opB = opB;
		row.request.opcode = opcode;
		row.request.shiftAmt = shiftAmt;
		row.expAlu = expectAlu(row.request);
		row.expMul = expectMul(row.request);
		rows.push_back(row);
	endtask

	task automatic buildDirected();
		logic [31:0]     ones;
		logic [31:0]     mulA [8];
		logic [31:0]     mulB [8];
		aluPkg::aluOp_t  mixOps [8];
		mulA = '{32'd0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h8000_0000,
			32'h7FFF_FFFF, 32'd12345, 32'h0001_0000, 32'hFFFF_0000};
		mulB = '{32'h0000_1234, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF,
			32'd2, 32'hFFFF_FD5A, 32'h0000_8000, 32'h0000_8000};
		mixOps = '{aluPkg::OP_MUL, aluPkg::OP_SUB, aluPkg::OP_MUL, aluPkg::OP_SLL,
			aluPkg::OP_MUL, aluPkg::aluOp_t'(5'd7), aluPkg::OP_MUL, aluPkg::OP_MUL};
		// carry out of every slice boundary in turn
		for (int s = 1; s <= 8; s++) begin
			ones = 32'hFFFF_FFFF >> (32 - 4 * s);
			addRow(ones, 32'd1, aluPkg::OP_ADD, 5'd0);
		end
		addRow(32'h7FFF_FFFF, 32'd1, aluPkg::OP_ADD, 5'd0);
		addRow(32'h8000_0000, 32'd1, aluPkg::OP_SUB, 5'd0);
		addRow(32'h8000_0000, 32'h7FFF_FFFF, aluPkg::OP_SUB, 5'd0);
		addRow(32'h7FFF_FFFF, 32'h8000_0000, aluPkg::OP_SUB, 5'd0);
		addRow(32'h8000_0000, 32'h8000_0000, aluPkg::OP_SUB, 5'd0);
		addRow(32'hFFFF_FFFF, 32'd1, aluPkg::OP_SUB, 5'd0);
		addRow(32'd1, 32'hFFFF_FFFF, aluPkg::OP_SUB, 5'd0);
		addRow(32'hF0F0_A5A5, 32'h0FF0_5A5A, aluPkg::OP_AND, 5'd0);
		addRow(32'hF0F0_A5A5, 32'h0FF0_5A5A, aluPkg::OP_OR, 5'd0);
		// every shift amount, negative and positive operand for sra
		for (int n = 0; n < 32; n++) begin
			addRow(32'h9234_5671, 32'd0, aluPkg::OP_SLL, 5'(n));
			addRow(32'h9234_5671, 32'd0, aluPkg::OP_SRA, 5'(n));
			addRow(32'h6234_5671, 32'd0, aluPkg::OP_SRA, 5'(n));
		end
		// isolated multiplies, one idle row between them
		for (int n = 0; n < 8; n++) begin
			addRow(mulA[n], mulB[n], aluPkg::OP_MUL, 5'd0);
			addRow(mulA[n], mulB[n], aluPkg::OP_ADD, 5'd0);
		end
		// back-to-back run, then multiplies mixed with other opcodes
		for (int n = 0; n < 8; n++) begin
			addRow(mulB[n], mulA[7-n], aluPkg::OP_MUL, 5'd0);
		end
		for (int n = 0; n < 8; n++) begin
			addRow(mulA[n], mulB[7-n], mixOps[n], 5'(n));
		end
	endtask

	task automatic buildRandom();
		int              pick;
		logic [31:0]     a;
		logic [31:0]     b;
		aluPkg::aluOp_t  opcode;
		for (int n = 0; n < 200; n++) begin
			pick = $urandom_range(0, 9);
			a = $urandom;
			b = $urandom;
			if (pick == 9) begin
				opcode = aluPkg::aluOp_t'(5'(7 + $urandom_range(0, 24)));
			end else if (pick >= 6) begin
				opcode = aluPkg::OP_MUL;
			end else begin
				opcode = aluPkg::aluOp_t'(5'(pick));
			end
			// narrow operands keep some products in range
			if ($urandom_range(0, 1) == 1) begin
				a = {{16{a[15]}}, a[15:0]};
				b = {{16{b[15]}}, b[15:0]};
			end
			addRow(a, b, opcode, 5'($urandom));
		end
	endtask

	task automatic abortRun();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic checkAlu(input aluPkg::aluResult_t expected);
		if (alu !== expected) begin
			$display("Fail at %0t: alu got %h expected %h", $time, alu, expected);
			abortRun();
		end
	endtask

	task automatic checkMul(input aluPkg::mulResult_t expected);
		logic mismatch;
		// product and overflow only count while valid
		mismatch = (mul.valid !== expected.valid) || (expected.valid && (mul !== expected));
		if (mismatch) begin
			$display("Fail at %0t: mul got %h expected %h", $time, mul, expected);
			abortRun();
		end
	endtask

	initial begin
		cycleCount = 0;
		@(posedge clk);
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycleLimit);
		abortRun();
	end

	initial begin
		void'($urandom(61));
		rst = 1'b1;
		request = '0;
		noProduct = '0;
		buildDirected();
		buildRandom();
		// idle rows let the last products drain
		for (int n = 0; n < aluPkg::boothStages; n++) begin
			addRow(32'd0, 32'd0, aluPkg::OP_ADD, 5'd0);
		end
		cycleLimit = (rows.size() + aluPkg::boothStages + 10) * 2;
		// nothing is due during the first boothStages cycles
		for (int n = 0; n < aluPkg::boothStages; n++) begin
			pendingMul.push_back(noProduct);
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		foreach (rows[i]) begin
			request = rows[i].request;
			pendingMul.push_back(rows[i].expMul);
			#1;
			checkAlu(rows[i].expAlu);
			checkMul(pendingMul.pop_front());
			@(posedge clk);
			#1;
		end
		if (i_aluTop.i_aluTop_checker.assertFailures == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Checker assertions failed %0d times",
				i_aluTop.i_aluTop_checker.assertFailures);
			abortRun();
		end
	end

endmodule

`default_nettype wire

/* verification/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic clk
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* verification/aluTop_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module aluTop_checker (
	input wire logic                clk,
	input wire logic                rst,
	input wire aluPkg::aluRequest_t request,
	input wire aluPkg::aluResult_t  alu,
	input wire aluPkg::mulResult_t  mul
);

	logic [aluPkg::boothStages-1:0] issueHistory;
	int                             assertFailures = 0;

	// one bit per edge, set when a multiply was sampled there
	always_ff @(posedge clk) begin
		if (rst) begin
			issueHistory <= '0;
		end else begin
			issueHistory <= {issueHistory[aluPkg::boothStages-2:0],
				request.opcode == aluPkg::OP_MUL};
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		mul.valid == issueHistory[aluPkg::boothStages-1])
	else begin
		assertFailures++;
		$error("mul.valid does not follow the multiply issued 16 edges earlier");
	end

	assert property (@(posedge clk) rst |=> !mul.valid)
	else begin
		assertFailures++;
		$error("mul.valid high right after a reset edge");
	end

	assert property (@(posedge clk)
		(request.opcode != aluPkg::OP_SUB) |-> (!alu.notEqual && !alu.lessThan))
	else begin
		assertFailures++;
		$error("compare flags set for an opcode other than subtract");
	end

	assert property (@(posedge clk) (request.opcode == aluPkg::OP_MUL) |-> (alu.result == '0))
	else begin
		assertFailures++;
		$error("single-cycle result not zero during a multiply");
	end

endmodule

bind aluTop aluTop_checker i_aluTop_checker (
	.clk     (clk),
	.rst     (rst),
	.request (request),
	.alu     (alu),
	.mul     (mul)
);

`default_nettype wire

/* verilog/aluTop.sv */
`timescale 1ns/100ps
`default_nettype none

module aluTop (
	input wire logic                clk,
	input wire logic                rst,
	input wire aluPkg::aluRequest_t request,
	output aluPkg::aluResult_t      alu,
	output aluPkg::mulResult_t      mul
);

	logic mulStart;

	assign mulStart = (request.opcode == aluPkg::OP_MUL);

	// combinational path, result in the same cycle
	singleCycleUnit i_singleCycleUnit (
		.request (request),
		.alu     (alu)
	);

	// product appears boothStages cycles after issue
	multPipeline i_multPipeline (
		.clk   (clk),
		.rst   (rst),
		.start (mulStart),
		.opA   (request.opA),
		.opB   (request.opB),
		.mul   (mul)
	);

endmodule

`default_nettype wire

/* verilog/multPipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module multPipeline (
	input wire logic                         clk,
	input wire logic                         rst,
	input wire logic                         start,
	input wire logic [aluPkg::dataWidth-1:0] opA,
	input wire logic [aluPkg::dataWidth-1:0] opB,
	output aluPkg::mulResult_t               mul
);

	aluPkg::boothState_t launch;
	aluPkg::boothState_t chain [aluPkg::boothStages+1];
	aluPkg::boothState_t stageQ [aluPkg::boothStages];
	aluPkg::boothState_t finalState;
	logic                upperMismatch;

	// multiplier sits in the low half, consumed two bits per step
	always_comb begin
		launch.multiplicand = opA;
		launch.acc = {{aluPkg::dataWidth{1'b0}}, opB};
		launch.extraBit = 1'b0;
		// nonzero operands with equal signs give a positive product
		launch.productPositive = ~(opA[aluPkg::dataWidth-1] ^ opB[aluPkg::dataWidth-1])
			& (|opA) & (|opB);
		launch.active = start;
	end

	assign chain[0] = launch;

	always_ff @(posedge clk) begin
		for (int k = 0; k < aluPkg::boothStages; k++) begin
			stageQ[k] <= chain[k];
			if (rst) begin
				stageQ[k].active <= 1'b0;
			end
		end
	end

	for (genvar k = 0; k < aluPkg::boothStages; k++) begin : gStep
		boothStage i_boothStage (
			.current (stageQ[k]),
			.next    (chain[k+1])
		);
	end

	assign finalState = chain[aluPkg::boothStages];

	// product fits only if the upper word is pure sign extension
	assign upperMismatch = |(finalState.acc[aluPkg::productWidth-1:aluPkg::dataWidth]
		^ {aluPkg::dataWidth{finalState.acc[aluPkg::dataWidth-1]}});

	assign mul.product = finalState.acc[aluPkg::dataWidth-1:0];
	assign mul.overflow = upperMismatch
		| (finalState.productPositive & finalState.acc[aluPkg::dataWidth-1]);
	assign mul.valid = finalState.active;

endmodule

`default_nettype wire

/* verilog/boothStage.sv */
`timescale 1ns/100ps
`default_nettype none

module boothStage (
	input wire aluPkg::boothState_t current,
	output aluPkg::boothState_t     next
);

	logic [2:0]                   window;
	logic                         subtract;
	logic [aluPkg::dataWidth+1:0] upperExt;
	logic [aluPkg::dataWidth+1:0] addend;
	logic [aluPkg::dataWidth+1:0] partial;
	logic [aluPkg::dataWidth-1:0] mcand;

	assign mcand = current.multiplicand;
	assign window = {current.acc[1:0], current.extraBit};

	// two guard bits so that +-2M cannot wrap the upper half
	assign upperExt = {
		{2{current.acc[aluPkg::productWidth-1]}},
		current.acc[aluPkg::productWidth-1:aluPkg::dataWidth]
	};

	// radix-4 recoding, top window bit selects subtract
	always_comb begin
		subtract = window[2];
		case (window)
			3'b001, 3'b010, 3'b101, 3'b110: begin
				addend = {{2{mcand[aluPkg::dataWidth-1]}}, mcand};
			end
			3'b011, 3'b100: begin
				addend = {mcand[aluPkg::dataWidth-1], mcand, 1'b0};
			end
			default: begin
				addend = '0;
			end
		endcase
	end

	assign partial = upperExt + (addend ^ {(aluPkg::dataWidth + 2){subtract}})
		+ {{(aluPkg::dataWidth + 1){1'b0}}, subtract};

	always_comb begin
		next = current;
		if (current.active) begin
			// arithmetic shift by two, the guard bits drop back out
			next.acc = {partial, current.acc[aluPkg::dataWidth-1:2]};
			next.extraBit = current.acc[1];
		end
	end

endmodule

`default_nettype wire

/* verilog/singleCycleUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module singleCycleUnit (
	input wire aluPkg::aluRequest_t request,
	output aluPkg::aluResult_t      alu
);

	logic [aluPkg::dataWidth-1:0] arith;
	logic [aluPkg::dataWidth-1:0] shifted;
	logic                         subNotEqual;
	logic                         subLessThan;
	logic                         isSra;

	assign isSra = (request.opcode == aluPkg::OP_SRA);

	addSubLogic i_addSubLogic (
		.a        (request.opA),
		.b        (request.opB),
		.op       (request.opcode),
		.sum      (arith),
		.notEqual (subNotEqual),
		.lessThan (subLessThan)
	);

	// shifted operand is always opA
	barrelShifter i_barrelShifter (
		.a               (request.opA),
		.amount          (request.shiftAmt),
		.arithmeticRight (isSra),
		.shifted         (shifted)
	);

	always_comb begin
		alu.result = '0;
		alu.notEqual = 1'b0;
		alu.lessThan = 1'b0;
		case (request.opcode)
			aluPkg::OP_ADD, aluPkg::OP_AND, aluPkg::OP_OR: begin
				alu.result = arith;
			end
			aluPkg::OP_SUB: begin
				alu.result = arith;
				// flags only make sense for the subtraction
				alu.notEqual = subNotEqual;
				alu.lessThan = subLessThan;
			end
			aluPkg::OP_SLL, aluPkg::OP_SRA: begin
				alu.result = shifted;
			end
			default: begin
				alu.result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/barrelShifter.sv */
`timescale 1ns/100ps
`default_nettype none

module barrelShifter (
	input wire logic [aluPkg::dataWidth-1:0]  a,
	input wire logic [aluPkg::shiftWidth-1:0] amount,
	input wire logic                          arithmeticRight,
	output logic [aluPkg::dataWidth-1:0]      shifted
);

	logic [aluPkg::dataWidth-1:0] word;
	logic                         fillBit;

	// right shifts replicate the sign, left shifts bring in zeros
	assign fillBit = arithmeticRight & a[aluPkg::dataWidth-1];

	always_comb begin
		int distance;
		word = a;
		// levels of 16, 8, 4, 2 and 1, one amount bit each
		for (int lvl = aluPkg::shiftWidth - 1; lvl >= 0; lvl--) begin
			distance = 1 << lvl;
			if (amount[lvl]) begin
				if (arithmeticRight) begin
					word = word >> distance;
					for (int f = 0; f < aluPkg::dataWidth; f++) begin
						if (f >= aluPkg::dataWidth - distance) begin
							word[f] = fillBit;
						end
					end
				end else begin
					word = word << distance;
				end
			end
		end
		shifted = word;
	end

endmodule

`default_nettype wire

/* verilog/addSubLogic.sv */
`timescale 1ns/100ps
`default_nettype none

module addSubLogic (
	input wire logic [aluPkg::dataWidth-1:0] a,
	input wire logic [aluPkg::dataWidth-1:0] b,
	input wire aluPkg::aluOp_t               op,
	output logic [aluPkg::dataWidth-1:0]     sum,
	output logic                             notEqual,
	output logic                             lessThan
);

	logic                            subtract;
	logic [aluPkg::dataWidth-1:0]    bOperand;
	logic [aluPkg::dataWidth-1:0]    gen;
	logic [aluPkg::dataWidth-1:0]    prop;
	logic [aluPkg::dataWidth-1:0]    arith;
	logic [aluPkg::sliceCount:0]     sliceCarry;
	logic [aluPkg::sliceCount-1:0]   groupGen;
	logic [aluPkg::sliceCount-1:0]   groupProp;
	logic                            bitCarry;
	logic                            msbCarryIn;
	logic                            topOverflow;

	assign subtract = (op == aluPkg::OP_SUB);

	// a - b computed as a + ~b + 1
	assign bOperand = b ^ {aluPkg::dataWidth{subtract}};
	assign gen = a & bOperand;
	assign prop = a ^ bOperand;

	always_comb begin
		int k;
		sliceCarry[0] = subtract;
		for (int s = 0; s < aluPkg::sliceCount; s++) begin
			bitCarry = sliceCarry[s];
			groupGen[s] = 1'b0;
			groupProp[s] = 1'b1;
			// carries inside the slice, plus its group generate and propagate
			for (int j = 0; j < aluPkg::sliceWidth; j++) begin
				k = s * aluPkg::sliceWidth + j;
				arith[k] = prop[k] ^ bitCarry;
				bitCarry = gen[k] | (prop[k] & bitCarry);
				groupGen[s] = gen[k] | (prop[k] & groupGen[s]);
				groupProp[s] = groupProp[s] & prop[k];
			end
			// slice carry out from the group terms only
			sliceCarry[s+1] = groupGen[s] | (groupProp[s] & sliceCarry[s]);
		end
	end

	// carry into the msb recovered from its sum bit
	assign msbCarryIn = arith[aluPkg::dataWidth-1] ^ prop[aluPkg::dataWidth-1];
	assign topOverflow = msbCarryIn ^ sliceCarry[aluPkg::sliceCount];

	always_comb begin
		case (op)
			aluPkg::OP_AND: sum = a & b;
			aluPkg::OP_OR:  sum = a | b;
			default:        sum = arith;
		endcase
	end

	assign notEqual = |arith;
	// signed compare, sign of the difference corrected by overflow
	assign lessThan = arith[aluPkg::dataWidth-1] ^ topOverflow;

endmodule

`default_nettype wire

/* verilog/aluPkg.sv */
`default_nettype none

package aluPkg;

	localparam int dataWidth = 32;
	localparam int productWidth = 64;
	localparam int shiftWidth = 5;
	localparam int boothStages = 16;
	localparam int sliceWidth = 4;
	localparam int sliceCount = dataWidth / sliceWidth;

	// opcodes 7 to 31 are not decoded
	typedef enum logic [4:0] {
		OP_ADD = 5'd0,
		OP_SUB = 5'd1,
		OP_AND = 5'd2,
		OP_OR  = 5'd3,
		OP_SLL = 5'd4,
		OP_SRA = 5'd5,
		OP_MUL = 5'd6
	} aluOp_t;

	typedef struct packed {
		logic [dataWidth-1:0]  opA;
		logic [dataWidth-1:0]  opB;
		aluOp_t                opcode;
		logic [shiftWidth-1:0] shiftAmt;
	} aluRequest_t;

	typedef struct packed {
		logic [dataWidth-1:0] result;
		logic                 notEqual;
		logic                 lessThan;
	} aluResult_t;

	typedef struct packed {
		logic [dataWidth-1:0] product;
		logic                 overflow;
		logic                 valid;
	} mulResult_t;

	// state handed from one booth step to the next
	typedef struct packed {
		logic [dataWidth-1:0]    multiplicand;
		logic [productWidth-1:0] acc;
		logic                    extraBit;
		logic                    productPositive;
		logic                    active;
	} boothState_t;

endpackage

`default_nettype wire
